/* hw/riscv_defines.sv */
/*
 * Shared definitions for the RV32I fetch front end
 * Widths, opcode, queue sizing and the fetch entry layout
 */
`default_nettype none

package riscv_defines;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_WIDTH      = 32;	// Instruction and address width
	localparam int IMEM_DEPTH_LOG2 = 8;	// 256 words of instruction memory

	////////////////////////////////////////////////////////////////////////////
	// Fetch queue sizing
	////////////////////////////////////////////////////////////////////////////

	localparam int QUEUE_DEPTH = 4;

	// Two free slots left when stall rises
	// One for the word in flight, one for the replayed word
	localparam int QUEUE_STALL_LEVEL = QUEUE_DEPTH - 2;

	// Opcode field, bits [6:0]
	localparam logic [6:0] OPCODE_JAL = 7'b110_1111;

	// One queue slot, instruction in the upper word
	typedef struct packed {
		logic [WORD_WIDTH-1:0] instruction;
		logic [WORD_WIDTH-1:0] pc;
	} fetch_entry_t;

endpackage

`default_nettype wire

/* hw/instruction_ram.sv */
/*
 * Instruction memory standing in for the I-cache
 * Load port for the program, fetch port with grant on request and data one cycle later
 */
`default_nettype none

module instruction_ram (
	input  wire                                       clk,
	input  wire                                       rst_n,

	// Program load port, word addressed
	input  wire                                       load_we_i,
	input  wire  [riscv_defines::IMEM_DEPTH_LOG2-1:0] load_addr_i,
	input  wire  [riscv_defines::WORD_WIDTH-1:0]      load_data_i,

	// Fetch port
	input  wire                                       instr_req_i,
	input  wire  [riscv_defines::WORD_WIDTH-1:0]      instr_addr_i,	// Byte address
	output logic                                      instr_gnt_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]      instr_rdata_o,
	output logic                                      instr_rvalid_o
);
	import riscv_defines::*;

	logic [WORD_WIDTH-1:0] mem [1 << IMEM_DEPTH_LOG2];

	// Never busy, every request accepted on the spot
	assign instr_gnt_o = instr_req_i;

	// Program writes land at the next edge
	always_ff @(posedge clk) begin
		if (load_we_i)
			mem[load_addr_i] <= load_data_i;
	end

	// Read data registered, so it shows up the cycle after the grant
	always_ff @(posedge clk) begin
		if (instr_req_i)
			instr_rdata_o <= mem[instr_addr_i[IMEM_DEPTH_LOG2+1:2]];	// Drop byte offset
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			instr_rvalid_o <= 1'b0;
		else
			instr_rvalid_o <= instr_req_i;	// One rvalid per grant
	end

endmodule

`default_nettype wire

/* hw/if_stage.sv */
/*
 * Instruction fetch stage
 * PC and fetch FSM on the req/gnt/rvalid bus, with stall replay, redirect and squash
 */
`default_nettype none

module if_stage (
	input  wire                                  clk,
	input  wire                                  rst_n,

	// Instruction memory bus
	output logic                                 instr_req_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] instr_addr_o,
	input  wire  [riscv_defines::WORD_WIDTH-1:0] instr_rdata_i,
	input  wire                                  instr_rvalid_i,	// Data for last granted addr
	input  wire                                  instr_gnt_i,

	// Core control
	input  wire                                  fetch_en_i,
	input  wire  [riscv_defines::WORD_WIDTH-1:0] pc_start_address_i,

	// Datapath
	input  wire  [riscv_defines::WORD_WIDTH-1:0] pc_branch_addr_i,	// Jump target
	output logic [riscv_defines::WORD_WIDTH-1:0] instruction_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] program_count_o,

	// Control path
	input  wire                                  fetch_stall_i,	// Queue near full
	input  wire                                  branch_pc_ctrl_i,	// Redirect strobe
	output logic                                 no_op_flag_o	// Low means push this cycle
);
	import riscv_defines::*;

	typedef enum logic [2:0] {
		RESET,
		IDLE,
		PRE_FETCH,
		FETCH,
		STALL,
		POST_STALL
	} fetch_state_t;

	fetch_state_t          fetch_state;
	fetch_state_t          next_fetch_state;
	logic [WORD_WIDTH-1:0] pc;	// Address on the bus
	logic [WORD_WIDTH-1:0] prev_pc;	// Address of the word arriving now
	logic [WORD_WIDTH-1:0] next_pc;
	logic [WORD_WIDTH-1:0] pc_plus_four;
	logic [WORD_WIDTH-1:0] stalled_instruction;
	logic                  held_valid;	// stalled_instruction still owed to the queue
	logic                  squash;	// Word in flight is from before a redirect
	logic                  arrival;
	logic                  capture;
	logic                  rewind;
	logic                  push_fetch;
	logic                  push_held;

	assign pc_plus_four = pc + 32'd4;

	////////////////////////////////////////////////////////////////////////////
	// Fetch FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (fetch_state)
			RESET, IDLE:
				next_fetch_state = fetch_en_i ? PRE_FETCH : IDLE;
			PRE_FETCH:
				next_fetch_state = fetch_en_i ? FETCH : IDLE;
			FETCH, POST_STALL: begin
				if (!fetch_en_i)
					next_fetch_state = IDLE;
				else if (branch_pc_ctrl_i)
					next_fetch_state = FETCH;	// Queue flushes, so no stall after a jump
				else if (fetch_stall_i)
					next_fetch_state = STALL;
				else
					next_fetch_state = FETCH;
			end
			STALL: begin
				if (!fetch_en_i)
					next_fetch_state = IDLE;
				else if (branch_pc_ctrl_i)
					next_fetch_state = FETCH;
				else if (fetch_stall_i)
					next_fetch_state = STALL;
				else
					next_fetch_state = POST_STALL;	// Replay the held word
			end
			default:
				next_fetch_state = RESET;
		endcase
	end

	// Only FETCH consumes read data, and not in the cycle after a redirect
	assign arrival = (fetch_state == FETCH) && instr_rvalid_i && !squash;
	assign push_fetch = arrival && !fetch_stall_i;
	assign capture = arrival && fetch_stall_i && (next_fetch_state == STALL);
	assign push_held = held_valid && (fetch_state == POST_STALL);

	// Word not pushed and fetch shutting down, so fetch it again later
	assign rewind = (next_fetch_state == IDLE) &&
		((arrival && fetch_stall_i) || ((fetch_state == STALL) && held_valid));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_state <= RESET;
			squash      <= 1'b0;
			held_valid  <= 1'b0;
		end else begin
			fetch_state <= next_fetch_state;
			squash      <= branch_pc_ctrl_i;
			held_valid  <= capture || (held_valid && (fetch_state == STALL) &&
				(next_fetch_state inside {STALL, POST_STALL}));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program counter
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (branch_pc_ctrl_i)
			next_pc = pc_branch_addr_i;	// Jump target beats everything
		else if (rewind)
			next_pc = prev_pc;
		else if ((next_fetch_state == FETCH) && instr_gnt_i)
			next_pc = pc_plus_four;
		else
			next_pc = pc;	// Hold, the request is repeated later
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= pc_start_address_i;
			prev_pc <= pc_start_address_i;
		end else begin
			pc <= next_pc;
			// prev_pc keeps the held word's address through the stall
			if ((fetch_state != STALL) && (next_fetch_state != STALL))
				prev_pc <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			stalled_instruction <= instr_rdata_i;
	end

	// Outputs
	assign instr_req_o     = fetch_state inside {PRE_FETCH, FETCH, POST_STALL};
	assign instr_addr_o    = pc;
	assign instruction_o   = (fetch_state == FETCH) ? instr_rdata_i : stalled_instruction;
	assign program_count_o = prev_pc;
	assign no_op_flag_o    = !(push_fetch || push_held);

endmodule

`default_nettype wire

/* hw/fetch_queue.sv */
/*
 * Fetch queue
 * Circular FIFO with flush and an early stall level for the fetch stage
 */
`default_nettype none

module fetch_queue #(
	parameter type entry_t = riscv_defines::fetch_entry_t
) (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         push_i,
	input  wire entry_t push_data_i,
	input  wire         pop_i,
	input  wire         flush_i,	// Drop everything, wins over push
	output entry_t      pop_data_o,	// Head entry, valid while not empty
	output logic        empty_o,
	output logic        stall_o
);
	import riscv_defines::*;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;

	entry_t entries [QUEUE_DEPTH];
	ptr_t   rd_ptr;
	ptr_t   wr_ptr;
	count_t count;
	logic   do_push;
	logic   do_pop;

	// Wraps for any depth, not only powers of two
	function automatic ptr_t ptr_inc(input ptr_t ptr);
		return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push_i && (count != count_t'(QUEUE_DEPTH));	// Never overwrite
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (!rst_n || flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Push and pop together keep the fill
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push && !flush_i)
			entries[wr_ptr] <= push_data_i;
	end

	assign pop_data_o = entries[rd_ptr];
	assign empty_o    = (count == '0);
	assign stall_o    = (count >= count_t'(QUEUE_STALL_LEVEL));

endmodule

`default_nettype wire

/* hw/jump_resolver.sv */
/*
 * Jump resolver
 * Drains the fetch queue, redirects fetch on JAL and retires instructions in order
 */
`default_nettype none

module jump_resolver (
	input  wire                                  clk,
	input  wire                                  rst_n,

	// Queue side
	input  wire  riscv_defines::fetch_entry_t    entry_i,	// Queue head
	input  wire                                  empty_i,
	input  wire                                  retire_stall_i,	// Back-pressure from outside
	output logic                                 pop_o,

	// Redirect to fetch, also flushes the queue
	output logic                                 redirect_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] target_o,

	// Retire stream
	output logic                                 retire_valid_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] retire_instr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] retire_pc_o
);
	import riscv_defines::*;

	logic [WORD_WIDTH-1:0] instr;
	logic                  is_jal;
	logic [WORD_WIDTH-1:0] jal_imm;

	assign instr = entry_i.instruction;

	// Take the head whenever there is one and the consumer is ready
	assign pop_o = !empty_i && !retire_stall_i;

	////////////////////////////////////////////////////////////////////////////
	// JAL decode
	////////////////////////////////////////////////////////////////////////////

	assign is_jal = (instr[6:0] == OPCODE_JAL);

	// J-type immediate, imm[20|10:1|11|19:12], bit 0 always zero
	assign jal_imm = {
		{12{instr[31]}},	// Sign, also imm[20]
		instr[19:12],
		instr[20],
		instr[30:21],
		1'b0
	};

	assign target_o   = entry_i.pc + jal_imm;
	assign redirect_o = pop_o && is_jal;	// Flushed queue keeps this to one cycle

	////////////////////////////////////////////////////////////////////////////
	// Retire
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n)
			retire_valid_o <= 1'b0;
		else
			retire_valid_o <= pop_o;	// JAL retires too
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			retire_instr_o <= instr;
			retire_pc_o    <= entry_i.pc;
		end
	end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
/*
 * Fetch front end top
 * Instruction memory, fetch stage, fetch queue and jump resolver
 */
`default_nettype none

module fetch_top (
	input  wire                                       clk,
	input  wire                                       rst_n,
	input  wire                                       fetch_en_i,
	input  wire  [riscv_defines::WORD_WIDTH-1:0]      pc_start_address_i,
	input  wire                                       retire_stall_i,

	// Program load
	input  wire                                       load_we_i,
	input  wire  [riscv_defines::IMEM_DEPTH_LOG2-1:0] load_addr_i,
	input  wire  [riscv_defines::WORD_WIDTH-1:0]      load_data_i,

	// Retired instructions, program order
	output logic                                      retire_valid_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]      retire_instr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0]      retire_pc_o
);
	import riscv_defines::*;

	////////////////////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////////////////////

	// Memory bus
	logic                  instr_req;
	logic                  instr_gnt;
	logic                  instr_rvalid;
	logic [WORD_WIDTH-1:0] instr_addr;
	logic [WORD_WIDTH-1:0] instr_rdata;

	// Fetch stage to queue
	logic [WORD_WIDTH-1:0] if_instr;
	logic [WORD_WIDTH-1:0] if_pc;
	logic                  no_op_flag;
	logic                  queue_push;
	logic                  queue_stall;

	// Queue to resolver and back
	fetch_entry_t          head_entry;
	logic                  queue_empty;
	logic                  queue_pop;
	logic                  redirect;
	logic [WORD_WIDTH-1:0] redirect_target;

	assign queue_push = !no_op_flag;

	instruction_ram instruction_ram_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.load_we_i      (load_we_i),
		.load_addr_i    (load_addr_i),
		.load_data_i    (load_data_i),
		.instr_req_i    (instr_req),
		.instr_addr_i   (instr_addr),
		.instr_gnt_o    (instr_gnt),
		.instr_rdata_o  (instr_rdata),
		.instr_rvalid_o (instr_rvalid)
	);

	if_stage if_stage_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.instr_req_o        (instr_req),
		.instr_addr_o       (instr_addr),
		.instr_rdata_i      (instr_rdata),
		.instr_rvalid_i     (instr_rvalid),
		.instr_gnt_i        (instr_gnt),
		.fetch_en_i         (fetch_en_i),
		.pc_start_address_i (pc_start_address_i),
		.pc_branch_addr_i   (redirect_target),
		.instruction_o      (if_instr),
		.program_count_o    (if_pc),
		.fetch_stall_i      (queue_stall),
		.branch_pc_ctrl_i   (redirect),
		.no_op_flag_o       (no_op_flag)
	);

	fetch_queue #(
		.entry_t (fetch_entry_t)
	) fetch_queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (queue_push),
		.push_data_i ({if_instr, if_pc}),	// Matches fetch_entry_t field order
		.pop_i       (queue_pop),
		.flush_i     (redirect),
		.pop_data_o  (head_entry),
		.empty_o     (queue_empty),
		.stall_o     (queue_stall)
	);

	jump_resolver jump_resolver_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.entry_i        (head_entry),
		.empty_i        (queue_empty),
		.retire_stall_i (retire_stall_i),
		.pop_o          (queue_pop),
		.redirect_o     (redirect),
		.target_o       (redirect_target),
		.retire_valid_o (retire_valid_o),
		.retire_instr_o (retire_instr_o),
		.retire_pc_o    (retire_pc_o)
	);

endmodule

`default_nettype wire

/* tests/fetch_tb.sv */
/*
 * Testbench for the fetch front end
 * Loads programs, walks them in a reference model and checks the retire stream
 */
`default_nettype none

module fetch_tb;
	import riscv_defines::*;

	// Fill takes about 330 cycles, each of the six runs well under 400
	localparam int                    MAX_CYCLES    = 4000;
	localparam int                    MEM_WORDS     = 1 << IMEM_DEPTH_LOG2;
	localparam logic [WORD_WIDTH-1:0] STRAIGHT_BASE = 32'h0000_0040;
	localparam logic [WORD_WIDTH-1:0] JUMP_BASE     = 32'h0000_0200;

	logic                       clk;
	logic                       rst_n;
	logic                       fetch_en_i;
	logic [WORD_WIDTH-1:0]      pc_start_address_i;
	logic                       retire_stall_i;
	logic                       load_we_i;
	logic [IMEM_DEPTH_LOG2-1:0] load_addr_i;
	logic [WORD_WIDTH-1:0]      load_data_i;
	logic                       retire_valid_o;
	logic [WORD_WIDTH-1:0]      retire_instr_o;
	logic [WORD_WIDTH-1:0]      retire_pc_o;

	// Program image as written through the load port
	logic [WORD_WIDTH-1:0] prog [MEM_WORDS];
	bit                    is_jal [MEM_WORDS];
	int                    jal_off [MEM_WORDS];	// Byte offset of each JAL

	logic [WORD_WIDTH-1:0] exp_pc [$];	// Expected retire stream
	logic [WORD_WIDTH-1:0] exp_instr [$];
	logic [WORD_WIDTH-1:0] halt_pc;	// Self-loop JAL that ends a program
	logic [WORD_WIDTH-1:0] halt_instr;

	string test_name;
	bit    checking;	// Compare process active
	bit    bp_enable;	// Random retire back-pressure
	int    halt_hits;
	int    retired;
	int    checks;
	int    errors;
	int    cycles;

	fetch_top fetch_top_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.fetch_en_i         (fetch_en_i),
		.pc_start_address_i (pc_start_address_i),
		.retire_stall_i     (retire_stall_i),
		.load_we_i          (load_we_i),
		.load_addr_i        (load_addr_i),
		.load_data_i        (load_data_i),
		.retire_valid_o     (retire_valid_o),
		.retire_instr_o     (retire_instr_o),
		.retire_pc_o        (retire_pc_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Program building and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [IMEM_DEPTH_LOG2-1:0] word_of(input logic [WORD_WIDTH-1:0] addr);
		return addr[IMEM_DEPTH_LOG2+1:2];
	endfunction

	// J-type encoding, rd is x1
	function automatic logic [WORD_WIDTH-1:0] jal_word(input int off);
		logic [20:0] imm;
		imm = 21'(off);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPCODE_JAL};
	endfunction

	// Walks the program from start until the self-loop, using the offsets as written
	function automatic void build_expected(input logic [WORD_WIDTH-1:0] start);
		logic [WORD_WIDTH-1:0]      pc;
		logic [IMEM_DEPTH_LOG2-1:0] w;
		bit                         done;
		int                         step;
		exp_pc.delete();
		exp_instr.delete();
		halt_hits = 0;
		retired   = 0;
		pc        = start;
		done      = 1'b0;
		for (step = 0; step < MEM_WORDS && !done; step++) begin
			w = word_of(pc);
			exp_pc.push_back(pc);
			exp_instr.push_back(prog[w]);
			if (is_jal[w] && jal_off[w] == 0) begin
				halt_pc    = pc;
				halt_instr = prog[w];
				done       = 1'b1;
			end else if (is_jal[w]) begin
				pc = pc + WORD_WIDTH'(jal_off[w]);
			end else begin
				pc = pc + 32'd4;
			end
		end
	endfunction

	task automatic load_word(input logic [WORD_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] data);
		@(posedge clk);
		load_we_i   <= 1'b1;
		load_addr_i <= word_of(addr);
		load_data_i <= data;
		prog[word_of(addr)] = data;
	endtask

	task automatic put_plain(input logic [WORD_WIDTH-1:0] addr);
		logic [WORD_WIDTH-1:0] r;
		r = $urandom();
		is_jal[word_of(addr)] = 1'b0;
		load_word(addr, {r[31:7], 7'b001_0011});	// OP-IMM, never a JAL
	endtask

	task automatic put_jal(input logic [WORD_WIDTH-1:0] addr, input int off);
		is_jal[word_of(addr)]  = 1'b1;
		jal_off[word_of(addr)] = off;
		load_word(addr, jal_word(off));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_dut(input logic [WORD_WIDTH-1:0] start);
		@(posedge clk);
		rst_n              <= 1'b0;
		pc_start_address_i <= start;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		assert (!retire_valid_o) else begin
			errors++;
			$display("error %s: retire_valid after reset expected 0 actual %b",
				test_name, retire_valid_o);
		end
	endtask

	// Fetch off, reset to start, reference rebuilt, fetch on
	task automatic start_program(input string name, input logic [WORD_WIDTH-1:0] start);
		test_name = name;
		checking  = 1'b0;
		@(posedge clk);
		fetch_en_i <= 1'b0;
		reset_dut(start);
		build_expected(start);
		checking = 1'b1;
		@(posedge clk);
		fetch_en_i <= 1'b1;
	endtask

	// Whole stream seen, then a few turns of the halt loop
	task automatic wait_for_halt();
		while (exp_pc.size() != 0 || halt_hits < 3)
			@(posedge clk);
		checking = 1'b0;
	endtask

	task automatic wait_for_retires(input int n);
		while (retired < n)
			@(posedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare, back-pressure and watchdog
	////////////////////////////////////////////////////////////////////////////

	// Outputs settle before the falling edge
	initial begin : compare
		logic [WORD_WIDTH-1:0] want_pc;
		logic [WORD_WIDTH-1:0] want_instr;
		forever begin
			@(negedge clk);
			if (checking && retire_valid_o) begin
				if (exp_pc.size() != 0) begin
					want_pc    = exp_pc.pop_front();
					want_instr = exp_instr.pop_front();
				end else begin
					want_pc    = halt_pc;	// Past the end only the halt loop may retire
					want_instr = halt_instr;
					halt_hits++;
				end
				checks++;
				retired++;
				assert (retire_pc_o == want_pc) else begin
					errors++;
					$display("error %s: pc expected %h actual %h",
						test_name, want_pc, retire_pc_o);
				end
				assert (retire_instr_o == want_instr) else begin
					errors++;
					$display("error %s: instr at pc %h expected %h actual %h",
						test_name, want_pc, want_instr, retire_instr_o);
				end
			end
		end
	end

	// Bursts up to three queue depths, so stall and replay get exercised
	initial begin : back_pressure
		int burst;
		burst          = 0;
		retire_stall_i <= 1'b0;
		forever begin
			@(posedge clk);
			if (bp_enable && burst == 0 && $urandom_range(3, 0) == 0)
				burst = int'($urandom_range(3 * QUEUE_DEPTH, 1));
			retire_stall_i <= bp_enable && (burst > 0);
			if (burst > 0)
				burst--;
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run not finished after %0d cycles", MAX_CYCLES);
		$display("%0d checks, %0d errors", checks, errors);
		$display("Something failed");
		$finish;
	end

	initial begin : main
		int w;
		rst_n              <= 1'b0;
		fetch_en_i         <= 1'b0;
		pc_start_address_i <= STRAIGHT_BASE;
		load_we_i          <= 1'b0;
		load_addr_i        <= '0;
		load_data_i        <= '0;
		checking  = 1'b0;
		bp_enable = 1'b0;
		checks    = 0;
		errors    = 0;
		halt_hits = 0;
		retired   = 0;
		test_name = "load";
		void'($urandom(32'hca31_acc0));
		reset_dut(STRAIGHT_BASE);

		// Filler everywhere, never a JAL, different at every word
		for (w = 0; w < MEM_WORDS; w++)
			load_word(WORD_WIDTH'(w * 4), {8'(w), ~8'(w), 8'(w) ^ 8'ha5, 8'h13});
		for (w = 0; w < 40; w++)
			put_plain(STRAIGHT_BASE + WORD_WIDTH'(w * 4));
		put_jal(STRAIGHT_BASE + 32'd160, 0);	// Halt
		put_plain(JUMP_BASE);
		put_plain(JUMP_BASE + 32'h04);
		put_jal(JUMP_BASE + 32'h08, 24);	// Forward to +0x20
		put_plain(JUMP_BASE + 32'h0c);	// Only reached by the backward jump
		put_jal(JUMP_BASE + 32'h10, 32);	// Loop exit to +0x30
		put_plain(JUMP_BASE + 32'h20);
		put_plain(JUMP_BASE + 32'h24);
		put_jal(JUMP_BASE + 32'h28, -28);	// Backward to +0x0c
		put_plain(JUMP_BASE + 32'h30);
		put_plain(JUMP_BASE + 32'h34);
		put_jal(JUMP_BASE + 32'h38, 64);	// Long forward to +0x78
		put_plain(JUMP_BASE + 32'h78);
		put_jal(JUMP_BASE + 32'h7c, 0);	// Halt
		@(posedge clk);
		load_we_i <= 1'b0;

		start_program("straight", STRAIGHT_BASE);
		wait_for_halt();
		start_program("jumps", JUMP_BASE);
		wait_for_halt();

		bp_enable = 1'b1;
		start_program("backpressure straight", STRAIGHT_BASE);
		wait_for_halt();
		start_program("backpressure jumps", JUMP_BASE);
		wait_for_halt();
		bp_enable = 1'b0;

		// Fetch dropped mid-program, queue drains, then resume
		start_program("fetch enable", STRAIGHT_BASE);
		wait_for_retires(10);
		@(posedge clk);
		fetch_en_i <= 1'b0;
		repeat (24) @(posedge clk);
		@(negedge clk);
		checks++;
		assert (!retire_valid_o) else begin
			errors++;
			$display("error %s: retire_valid with fetch off expected 0 actual %b",
				test_name, retire_valid_o);
		end
		@(posedge clk);
		fetch_en_i <= 1'b1;
		wait_for_halt();

		// Reset mid-stream with fetch left on, new start address
		start_program("reset restart", STRAIGHT_BASE);
		wait_for_retires(8);
		checking = 1'b0;
		reset_dut(JUMP_BASE);
		build_expected(JUMP_BASE);
		checking = 1'b1;
		wait_for_halt();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/riscv_defines.sv
hw/instruction_ram.sv
hw/if_stage.sv
hw/fetch_queue.sv
hw/jump_resolver.sv
hw/fetch_top.sv
tests/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module fetch_tb

out=$(./obj_dir/Vfetch_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
	exit 0
fi
exit 1
